//--- Bender.yml
package:
  name: busDatapath

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dpCtrlPkg.sv
      - verilog/aluPkg.sv
      - verilog/regFile.sv
      - verilog/specialRegs.sv
      - verilog/busMux.sv
      - verilog/alu.sv
      - verilog/dataPath.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/dataPath_checker.sv
      - tb/dataPath_tb.sv

//--- busDatapath.f
+incdir+verilog
verilog/dpCtrlPkg.sv
verilog/aluPkg.sv
verilog/regFile.sv
verilog/specialRegs.sv
verilog/busMux.sv
verilog/alu.sv
verilog/dataPath.sv
tb/dataPath_checker.sv
tb/dataPath_tb.sv

//--- tb/dataPath_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "dp_cfg.svh"

module dataPath_checker (
	input logic                 Clock,
	input logic                 arstN,
	input dpCtrlPkg::busSrc     src,
	input logic [`DP_WIDTH-1:0] busData,
	input logic                 busConflict
);

	assert property (@(posedge Clock) !arstN |-> !busConflict)
		else $error("busConflict high while reset is active");

	// counted over every out strobe, general registers included
	assert property (@(posedge Clock) disable iff (!arstN)
		busConflict == ($countones(src) > 1))
		else $error("busConflict does not match the number of out strobes");

	assert property (@(posedge Clock) disable iff (!arstN) (src == '0) |-> (busData == '0))
		else $error("bus not zero with no out strobe high");

endmodule

bind dataPath dataPath_checker i_checker (
	.Clock       (Clock),
	.arstN       (arstN),
	.src         (src),
	.busData     (busData),
	.busConflict (busConflict)
);

`default_nettype wire

//--- tb/dataPath_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dp_cfg.svh"

module dataPath_tb;

	localparam int MaxCycles = 200; // bound on every wait loop

	logic                 Clock;
	logic                 arstN;
	logic                 read;
	aluPkg::aluOp         op;
	logic [`DP_WIDTH-1:0] mDataIn;
	logic [`DP_WIDTH-1:0] inPortData;
	dpCtrlPkg::busSrc     src;
	dpCtrlPkg::regLoad    load;
	logic [`DP_WIDTH-1:0] busData;
	logic [`DP_WIDTH-1:0] mdrData;
	logic [`DP_WIDTH-1:0] marAddr;
	logic                 busConflict;

	dataPath i_dut (.*);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	task automatic stopWithFailure(input string why);
		if (why != "") begin
			$display("%s", why);
		end
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	// flag 1 checks the bus, 2 the MAR port, 3 the conflict flag, 0 nothing
	task automatic checkLine(input string name, input logic [31:0] chk,
		input logic [31:0] expV);
		logic [31:0] actual;
		if (chk != 32'd0) begin
			case (chk)
				32'd1: actual = busData;
				32'd2: actual = marAddr;
				32'd3: actual = {31'd0, busConflict};
				default: stopWithFailure("unknown check flag in the vectors file");
			endcase
			assert (actual === expV) else begin
				$display("MISMATCH %s expected %h actual %h", name, expV, actual);
				stopWithFailure("");
			end
		end
	endtask

	initial begin
		int fd;
		int cycles;
		int n;
		string line;
		string name;
		logic [31:0] rdV, opV, mdV, ipV, srcV, ldV, chk, expV;
		logic [31:0] mdrExp;
		arstN = 1'b0;
		read = 1'b0;
		op = aluPkg::aluOp'(4'd0);
		mDataIn = '0;
		inPortData = '0;
		src = '0;
		load = '0;
		mdrExp = '0; // MDR clears in reset
		fd = $fopen("tb/dataPath_vectors.txt", "r");
		if (fd == 0) begin
			stopWithFailure("could not open tb/dataPath_vectors.txt");
		end
		repeat (3) @(posedge Clock);
		arstN <= 1'b1;
		cycles = 0;
		while (arstN !== 1'b1) begin
			@(posedge Clock);
			cycles++;
			if (cycles > MaxCycles) begin
				stopWithFailure("timed out waiting for reset release");
			end
		end
		cycles = 0;
		while (!$feof(fd)) begin
			@(posedge Clock);
			cycles++;
			if (cycles > MaxCycles) begin
				stopWithFailure("timed out before the end of the vectors file");
			end
			n = 0;
			while (n != 9 && !$feof(fd)) begin // skips comment and blank lines
				line = "";
				void'($fgets(line, fd));
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, rdV, opV, mdV,
					ipV, srcV, ldV, chk, expV);
			end
			if (n == 9) begin
				read <= rdV[0];
				op <= aluPkg::aluOp'(opV[3:0]);
				mDataIn <= mdV;
				inPortData <= ipV;
				src <= dpCtrlPkg::busSrc'(srcV[23:0]);
				load <= dpCtrlPkg::regLoad'(ldV[22:0]);
				@(negedge Clock); // outputs settled, next edge not yet taken
				checkLine(name, chk, expV);
				assert (mdrData === mdrExp) else begin
					$display("MISMATCH %s mdrData expected %h actual %h", name, mdrExp,
						mdrData);
					stopWithFailure("");
				end
				if (ldV[2]) begin
					mdrExp = rdV[0] ? mdV : expV; // memory word or the expected bus word
				end
			end
		end
		$fclose(fd);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/dataPath_vectors.txt
# name read op mDataIn inPortData src load chk expected, all hex; chk 1 bus 2 marAddr 3 conflict
# src r[23:8] hi lo zHigh zLow pc mdr inPort y ; load r[22:7] hi lo z pc mdr mar y
rst_r5 0 0 00000000 00000000 002000 000000 1 00000000
rst_zhi 0 0 00000000 00000000 000020 000000 1 00000000
rst_y 0 0 00000000 00000000 000001 000000 1 00000000
mov_mdr 1 0 0000000C 00000000 000000 000004 1 00000000
mov_r1 0 0 00000000 00000000 000004 000100 1 0000000C
mov_y 0 0 00000000 00000000 000200 000001 1 0000000C
rd_y 0 0 00000000 00000000 000001 000000 1 0000000C
ld_m5 1 0 FFFFFFFB 00000000 000000 000004 1 00000000
div 0 B 00000000 00000000 000004 000010 1 FFFFFFFB
div_lo 0 0 00000000 00000000 000010 000020 1 FFFFFFFE
div_hi 0 0 00000000 00000000 000020 000040 1 00000002
rd_lo 0 0 00000000 00000000 000040 000000 1 FFFFFFFE
rd_hi 0 0 00000000 00000000 000080 000000 1 00000002
div0 0 B 00000000 00000000 000000 000010 1 00000000
div0_lo 0 0 00000000 00000000 000010 000000 1 FFFFFFFF
div0_hi 0 0 00000000 00000000 000020 000000 1 0000000C
mul 0 A 00000000 00000000 000004 000010 1 FFFFFFFB
mul_lo 0 0 00000000 00000000 000010 000000 1 FFFFFFC4
mul_hi 0 0 00000000 00000000 000020 000000 1 FFFFFFFF
add 0 1 00000000 00000000 000004 000010 1 FFFFFFFB
sub 0 2 00000000 00000000 000010 000010 1 00000007
and 0 3 00000000 00000000 000010 000010 1 00000005
or 0 4 00000000 00000000 000010 000010 1 00000004
shl 0 5 00000000 00000000 000010 000010 1 0000000C
neg 0 7 00000000 00000000 000010 000010 1 0000C000
not 0 8 00000000 00000000 000010 000010 1 FFFF4000
y_m5 0 0 00000000 00000000 000004 000001 1 FFFFFFFB
shra 0 6 00000000 00000000 000010 000010 1 0000BFFF
shra_lo 0 0 00000000 00000000 000010 000000 1 FFFFFFFF
pc_inc 0 9 00000000 00000000 000008 000010 1 00000000
z_pc 0 0 00000000 00000000 000010 000008 1 00000001
pc_mar 0 0 00000000 00000000 000008 000002 1 00000001
mar_out 0 0 00000000 00000000 000000 000000 2 00000001
conflict 0 0 00000000 00000000 000011 000000 3 00000001

//--- verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "dp_cfg.svh"

module alu (
	input  aluPkg::aluOp         op,
	input  logic [`DP_WIDTH-1:0] a,
	input  logic [`DP_WIDTH-1:0] b,
	output aluPkg::aluResult     result
);

	localparam int ShW = $clog2(`DP_WIDTH);

	logic signed [2*`DP_WIDTH-1:0] product;
	logic signed [`DP_WIDTH-1:0]   quotient;
	logic signed [`DP_WIDTH-1:0]   remainder;

	assign product = $signed(a) * $signed(b); // operands sign extended to 64 bits

	// signed divide truncates toward zero
	always_comb begin
		if (b == '0) begin
			quotient = '1;
			remainder = $signed(a); // dividend passes through
		end else begin
			quotient = $signed(a) / $signed(b);
			remainder = $signed(a) % $signed(b);
		end
	end

	always_comb begin
		result = '0;
		case (op)
			aluPkg::opAdd: result.low = a + b;
			aluPkg::opSub: result.low = a - b;
			aluPkg::opAnd: result.low = a & b;
			aluPkg::opOr: result.low = a | b;
			aluPkg::opShl: result.low = a << b[ShW-1:0];
			aluPkg::opShra: result.low = $signed(a) >>> b[ShW-1:0];
			aluPkg::opNeg: result.low = -b; // unary ops act on the bus
			aluPkg::opNot: result.low = ~b;
			aluPkg::opIncPc: result.low = b + 1'b1;
			aluPkg::opMul: result = aluPkg::aluResult'(product);
			aluPkg::opDiv: begin
				result.high = remainder;
				result.low = quotient;
			end
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/aluPkg.sv
`default_nettype none

`include "dp_cfg.svh"

package aluPkg;

	// code 0 is left free and gives a zero result
	typedef enum logic [3:0] {
		opAdd = 4'd1,
		opSub = 4'd2,
		opAnd = 4'd3,
		opOr = 4'd4,
		opShl = 4'd5,
		opShra = 4'd6, // arithmetic shift right
		opNeg = 4'd7,
		opNot = 4'd8,
		opIncPc = 4'd9, // bus plus one
		opMul = 4'd10,
		opDiv = 4'd11
	} aluOp;

	typedef struct packed {
		logic [`DP_WIDTH-1:0] high; // product high or remainder
		logic [`DP_WIDTH-1:0] low; // product low, quotient or plain result
	} aluResult;

endpackage

`default_nettype wire

//--- verilog/busMux.sv
`timescale 1ns/10ps
`default_nettype none

`include "dp_cfg.svh"

module busMux (
	input  dpCtrlPkg::busSrc     src,
	input  logic [`DP_WIDTH-1:0] rData,
	input  logic [`DP_WIDTH-1:0] hi,
	input  logic [`DP_WIDTH-1:0] lo,
	input  logic [`DP_WIDTH-1:0] zHigh,
	input  logic [`DP_WIDTH-1:0] zLow,
	input  logic [`DP_WIDTH-1:0] pc,
	input  logic [`DP_WIDTH-1:0] mdr,
	input  logic [`DP_WIDTH-1:0] inPort,
	input  logic [`DP_WIDTH-1:0] y,
	output logic [`DP_WIDTH-1:0] busData,
	output logic                 busConflict
);

	localparam int NumSrc = 9;

	logic [NumSrc-1:0]    sel;
	logic [`DP_WIDTH-1:0] cand [NumSrc];

	// general registers collapse to one line, regFile already picked the word
	assign sel = {|src.r, src.hi, src.lo, src.zHigh, src.zLow,
		src.pc, src.mdr, src.inPort, src.y};

	assign cand[8] = rData;
	assign cand[7] = hi;
	assign cand[6] = lo;
	assign cand[5] = zHigh;
	assign cand[4] = zLow;
	assign cand[3] = pc;
	assign cand[2] = mdr;
	assign cand[1] = inPort;
	assign cand[0] = y;

	always_comb begin
		busData = '0; // idle bus reads zero
		for (int i = 0; i < NumSrc; i++) begin
			busData = busData | ({`DP_WIDTH{sel[i]}} & cand[i]);
		end
	end

	// counted over every strobe, so two general registers also conflict
	assign busConflict = $countones(src) > 1;

endmodule

`default_nettype wire

//--- verilog/dataPath.sv
`timescale 1ns/10ps
`default_nettype none

`include "dp_cfg.svh"

module dataPath (
	input  logic                 Clock,
	input  logic                 arstN,
	input  logic                 read,
	input  aluPkg::aluOp         op,
	input  logic [`DP_WIDTH-1:0] mDataIn,
	input  logic [`DP_WIDTH-1:0] inPortData,
	input  dpCtrlPkg::busSrc     src,
	input  dpCtrlPkg::regLoad    load,
	output logic [`DP_WIDTH-1:0] busData,
	output logic [`DP_WIDTH-1:0] mdrData,
	output logic [`DP_WIDTH-1:0] marAddr,
	output logic                 busConflict
);

	logic [`DP_WIDTH-1:0] rData;
	logic [`DP_WIDTH-1:0] pc;
	logic [`DP_WIDTH-1:0] y;
	logic [`DP_WIDTH-1:0] hi;
	logic [`DP_WIDTH-1:0] lo;
	logic [`DP_WIDTH-1:0] inPort;
	aluPkg::aluResult     z;
	aluPkg::aluResult     aluOut; // next Z value

	regFile i_regFile (
		.Clock   (Clock),
		.arstN   (arstN),
		.load    (load),
		.src     (src),
		.busData (busData),
		.rData   (rData)
	);

	specialRegs i_specialRegs (
		.Clock      (Clock),
		.arstN      (arstN),
		.load       (load),
		.read       (read),
		.mDataIn    (mDataIn),
		.inPortData (inPortData),
		.busData    (busData),
		.zIn        (aluOut),
		.pc         (pc),
		.mdr        (mdrData),
		.mar        (marAddr),
		.y          (y),
		.hi         (hi),
		.lo         (lo),
		.inPort     (inPort),
		.z          (z)
	);

	busMux i_busMux (
		.src         (src),
		.rData       (rData),
		.hi          (hi),
		.lo          (lo),
		.zHigh       (z.high),
		.zLow        (z.low),
		.pc          (pc),
		.mdr         (mdrData),
		.inPort      (inPort),
		.y           (y),
		.busData     (busData),
		.busConflict (busConflict)
	);

	alu i_alu (
		.op     (op),
		.a      (y), // Y is always operand A
		.b      (busData),
		.result (aluOut)
	);

endmodule

`default_nettype wire

//--- verilog/dpCtrlPkg.sv
`default_nettype none

`include "dp_cfg.svh"

package dpCtrlPkg;

	// out strobes, at most one high per cycle
	typedef struct packed {
		logic [`DP_NUM_REGS-1:0] r; // R15..R0 onto the bus
		logic hi;
		logic lo;
		logic zHigh; // upper half of Z
		logic zLow; // lower half of Z
		logic pc;
		logic mdr;
		logic inPort;
		logic y;
	} busSrc;

	// in strobes, sampled on the rising clock edge
	typedef struct packed {
		logic [`DP_NUM_REGS-1:0] r; // R15..R0 load from the bus
		logic hi;
		logic lo;
		logic z; // both halves of Z from the ALU
		logic pc;
		logic mdr; // source chosen by read
		logic mar;
		logic y;
	} regLoad;

endpackage

`default_nettype wire

//--- verilog/dp_cfg.svh
`ifndef DP_CFG_SVH
`define DP_CFG_SVH

// width of the shared bus and of every register
`define DP_WIDTH 32

// general purpose registers R0 to R15
`define DP_NUM_REGS 16

`endif

//--- verilog/regFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "dp_cfg.svh"

module regFile (
	input  logic                 Clock,
	input  logic                 arstN,
	input  dpCtrlPkg::regLoad    load,
	input  dpCtrlPkg::busSrc     src,
	input  logic [`DP_WIDTH-1:0] busData,
	output logic [`DP_WIDTH-1:0] rData
);

	logic [`DP_WIDTH-1:0] regs [`DP_NUM_REGS];

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `DP_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `DP_NUM_REGS; i++) begin
				if (load.r[i]) begin
					regs[i] <= busData; // several may load the same word
				end
			end
		end
	end

	// and-or select, so the bus mux sees a single register candidate
	always_comb begin
		rData = '0;
		for (int i = 0; i < `DP_NUM_REGS; i++) begin
			if (src.r[i]) begin
				rData = rData | regs[i];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/specialRegs.sv
`timescale 1ns/10ps
`default_nettype none

`include "dp_cfg.svh"

module specialRegs (
	input  logic                 Clock,
	input  logic                 arstN,
	input  dpCtrlPkg::regLoad    load,
	input  logic                 read,
	input  logic [`DP_WIDTH-1:0] mDataIn,
	input  logic [`DP_WIDTH-1:0] inPortData,
	input  logic [`DP_WIDTH-1:0] busData,
	input  aluPkg::aluResult     zIn,
	output logic [`DP_WIDTH-1:0] pc,
	output logic [`DP_WIDTH-1:0] mdr,
	output logic [`DP_WIDTH-1:0] mar,
	output logic [`DP_WIDTH-1:0] y,
	output logic [`DP_WIDTH-1:0] hi,
	output logic [`DP_WIDTH-1:0] lo,
	output logic [`DP_WIDTH-1:0] inPort,
	output aluPkg::aluResult     z
);

	logic [`DP_WIDTH-1:0] mdrNext;

	assign mdrNext = read ? mDataIn : busData; // memory word while reading

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			mdr <= '0;
			mar <= '0;
			y <= '0;
			hi <= '0;
			lo <= '0;
			inPort <= '0;
			z <= '0;
		end else begin
			inPort <= inPortData; // free running sample
			if (load.pc) begin
				pc <= busData;
			end
			if (load.mdr) begin
				mdr <= mdrNext;
			end
			if (load.mar) begin
				mar <= busData;
			end
			if (load.y) begin
				y <= busData;
			end
			if (load.hi) begin
				hi <= busData;
			end
			if (load.lo) begin
				lo <= busData;
			end
			if (load.z) begin
				z <= zIn; // both halves in one step
			end
		end
	end

endmodule

`default_nettype wire
